//--- src/mpmc_consts.svh
`ifndef MPMC_CONSTS_SVH
`define MPMC_CONSTS_SVH

// Requester byte address
`define MPMC_ADDR_BITS 32

// Address presented on the memory port
`define MPMC_MEM_ADDR_BITS 29

// One memory line and its byte mask
`define MPMC_LINE_BITS 128
`define MPMC_MASK_BITS 16

// Requester channels behind the one memory port
`define MPMC_NUM_CH 3

// Bits below this one select a byte inside the line
`define MPMC_LINE_LSB 4

`endif

//--- src/mpmc_pkg.sv
`include "mpmc_consts.svh"

package mpmc_pkg;

	typedef logic [`MPMC_LINE_BITS-1:0] line_t;
	// A set bit keeps the byte in memory unchanged
	typedef logic [`MPMC_MASK_BITS-1:0] mask_t;
	typedef logic [`MPMC_ADDR_BITS-1:0] addr_t;
	typedef logic [1:0] ch_idx_t;

	typedef enum logic [2:0] {
		IDLE,
		PRESET,
		SEND_DATA,
		SET_CMD_WR,
		SET_CMD_RD,
		WAIT_RD
	} seq_state_t;

	// Native port opcodes
	typedef enum logic [2:0] {
		CMD_WRITE = 3'd0,
		CMD_READ  = 3'd1
	} mem_cmd_t;

endpackage

//--- src/mpmc_channel.sv
`timescale 1ns/100ps
`include "mpmc_consts.svh"

module mpmc_channel #(
	parameter int DATA_BITS = 128
) (
	input  logic                   mem_ui_clk,
	input  logic                   mem_ui_rst,
	input  logic                   cyc,
	input  logic                   we,
	input  logic [DATA_BITS/8-1:0] sel,
	input  mpmc_pkg::addr_t        adr,
	input  logic [DATA_BITS-1:0]   dati,
	output logic                   ack,
	output logic [DATA_BITS-1:0]   dato,
	output logic                   svc_req,
	output logic                   svc_wr,
	output mpmc_pkg::addr_t        line_adr,
	output mpmc_pkg::line_t        wr_line,
	output mpmc_pkg::mask_t        wr_mask,
	input  logic                   fill_hit,
	input  mpmc_pkg::line_t        fill_data,
	input  logic                   wr_done,
	input  logic                   inval_valid,
	input  mpmc_pkg::addr_t        inval_line
);
	localparam int LANES = `MPMC_LINE_BITS / DATA_BITS;
	localparam int TAG_BITS = `MPMC_ADDR_BITS - `MPMC_LINE_LSB;

	logic                tag_valid;
	logic [TAG_BITS-1:0] tag;
	mpmc_pkg::line_t     cache_line;
	logic                tag_hit;
	logic                ack_set;
	logic [1:0]          lane;
	mpmc_pkg::mask_t     sel_bytes;

	// ============================
	// Hit test and service request
	// ============================
	assign tag_hit = tag_valid && (tag == adr[`MPMC_ADDR_BITS-1:`MPMC_LINE_LSB]);

	// No new request while the ack for this one is out
	assign svc_req = cyc && !ack && (we || !tag_hit);
	assign svc_wr = we;

	// Reads ack off the cache, writes off the accepted command
	assign ack_set = cyc && !ack && ((!we && tag_hit) || (we && wr_done));

	// ============================
	// Write formatting
	// ============================
	// Narrow channels pick one 32-bit lane, a full-width channel has only lane 0
	assign lane = (LANES > 1) ? adr[`MPMC_LINE_LSB-1:2] : 2'd0;
	assign line_adr = {adr[`MPMC_ADDR_BITS-1:`MPMC_LINE_LSB], {`MPMC_LINE_LSB{1'b0}}};
	assign wr_line = {LANES{dati}};
	assign sel_bytes = mpmc_pkg::mask_t'(sel) << (lane * (DATA_BITS / 8));
	assign wr_mask = ~sel_bytes;

	// ============================
	// Cache line
	// ============================
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			tag_valid <= 1'b0;
		end else if (fill_hit) begin
			tag_valid <= 1'b1;
		end else if (inval_valid && tag == inval_line[`MPMC_ADDR_BITS-1:`MPMC_LINE_LSB]) begin
			// Another write touched this line
			tag_valid <= 1'b0;
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (fill_hit) begin
			tag <= adr[`MPMC_ADDR_BITS-1:`MPMC_LINE_LSB];
			cache_line <= fill_data;
		end
	end

	// Acknowledge, one cycle wide
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			ack <= 1'b0;
		end else begin
			ack <= ack_set;
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (ack_set) begin
			dato <= cache_line[lane * DATA_BITS +: DATA_BITS];
		end
	end

endmodule

//--- src/mpmc_arbiter.sv
`timescale 1ns/100ps
`include "mpmc_consts.svh"

module mpmc_arbiter (
	input  logic                    mem_ui_clk,
	input  logic                    mem_ui_rst,
	input  logic [`MPMC_NUM_CH-1:0] svc_req,
	input  logic [`MPMC_NUM_CH-1:0] svc_wr,
	input  logic                    busy,
	output logic                    grant_valid,
	output mpmc_pkg::ch_idx_t       grant_ch
);
	logic [`MPMC_NUM_CH-1:0] wr_req;
	logic [`MPMC_NUM_CH-1:0] rd_req;
	mpmc_pkg::ch_idx_t       pick;

	assign wr_req = svc_req & svc_wr;
	assign rd_req = svc_req & ~svc_wr;

	// Scan high to low so the lowest channel is left standing
	// Writes are scanned last and override any read miss
	always_comb begin
		pick = '0;
		for (int i = `MPMC_NUM_CH - 1; i >= 0; i--) begin
			if (rd_req[i])
				pick = mpmc_pkg::ch_idx_t'(i);
		end
		for (int i = `MPMC_NUM_CH - 1; i >= 0; i--) begin
			if (wr_req[i])
				pick = mpmc_pkg::ch_idx_t'(i);
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			grant_valid <= 1'b0;
			grant_ch <= '0;
		end else begin
			grant_valid <= !busy && (|svc_req);
			if (!busy && (|svc_req))
				grant_ch <= pick;
		end
	end

endmodule

//--- src/mpmc_sequencer.sv
`timescale 1ns/100ps
`include "mpmc_consts.svh"

module mpmc_sequencer (
	input  logic                                mem_ui_clk,
	input  logic                                mem_ui_rst,
	input  logic                                grant_valid,
	input  mpmc_pkg::ch_idx_t                   grant_ch,
	input  logic                                grant_wr,
	input  mpmc_pkg::addr_t [`MPMC_NUM_CH-1:0] line_adr_all,
	input  mpmc_pkg::line_t [`MPMC_NUM_CH-1:0] wr_line_all,
	input  mpmc_pkg::mask_t [`MPMC_NUM_CH-1:0] wr_mask_all,
	output logic                                busy,
	output logic                                fill_valid,
	output mpmc_pkg::ch_idx_t                   fill_ch,
	output mpmc_pkg::line_t                     fill_data,
	output logic                                wr_done_valid,
	output mpmc_pkg::ch_idx_t                   wr_done_ch,
	output logic                                inval_valid,
	output mpmc_pkg::addr_t                     inval_line,
	output logic                                mem_en,
	output mpmc_pkg::mem_cmd_t                  mem_cmd,
	output logic [`MPMC_MEM_ADDR_BITS-1:0]      mem_addr,
	output logic                                mem_wdf_wren,
	output logic                                mem_wdf_end,
	output mpmc_pkg::line_t                     mem_wdf_data,
	output mpmc_pkg::mask_t                     mem_wdf_mask,
	input  logic                                mem_rdy,
	input  logic                                mem_wdf_rdy,
	input  mpmc_pkg::line_t                     mem_rd_data,
	input  logic                                mem_rd_data_valid
);
	mpmc_pkg::seq_state_t state;
	mpmc_pkg::ch_idx_t    cur_ch;
	logic                 cur_wr;
	mpmc_pkg::addr_t      cur_line;

	// Stay busy through the strobes so a served channel is not granted again
	assign busy = (state != mpmc_pkg::IDLE) || grant_valid || fill_valid || wr_done_valid;

	// ============================
	// Memory port
	// ============================
	assign mem_addr = cur_line[`MPMC_MEM_ADDR_BITS-1:0];
	assign mem_en = (state == mpmc_pkg::SET_CMD_WR) || (state == mpmc_pkg::SET_CMD_RD);
	assign mem_cmd = (state == mpmc_pkg::SET_CMD_RD) ? mpmc_pkg::CMD_READ : mpmc_pkg::CMD_WRITE;
	assign mem_wdf_wren = (state == mpmc_pkg::SEND_DATA);
	assign mem_wdf_end = (state == mpmc_pkg::SEND_DATA);

	// The channel index holds until the next grant, after the strobes are gone
	assign fill_ch = cur_ch;
	assign wr_done_ch = cur_ch;
	assign inval_valid = wr_done_valid;
	assign inval_line = cur_line;

	// ============================
	// FSM
	// ============================
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			state <= mpmc_pkg::IDLE;
			fill_valid <= 1'b0;
			wr_done_valid <= 1'b0;
		end else begin
			fill_valid <= 1'b0;
			wr_done_valid <= 1'b0;
			case (state)
				mpmc_pkg::IDLE:
					if (grant_valid)
						state <= mpmc_pkg::PRESET;
				mpmc_pkg::PRESET:
					state <= cur_wr ? mpmc_pkg::SEND_DATA : mpmc_pkg::SET_CMD_RD;
				mpmc_pkg::SEND_DATA:
					if (mem_wdf_rdy)
						state <= mpmc_pkg::SET_CMD_WR;
				mpmc_pkg::SET_CMD_WR:
					if (mem_rdy) begin
						wr_done_valid <= 1'b1;
						state <= mpmc_pkg::IDLE;
					end
				mpmc_pkg::SET_CMD_RD:
					if (mem_rdy)
						state <= mpmc_pkg::WAIT_RD;
				mpmc_pkg::WAIT_RD:
					if (mem_rd_data_valid) begin
						fill_valid <= 1'b1;
						state <= mpmc_pkg::IDLE;
					end
				default:
					state <= mpmc_pkg::IDLE;
			endcase
		end
	end

	// Request payload, captured from the granted channel
	always_ff @(posedge mem_ui_clk) begin
		if (state == mpmc_pkg::IDLE && grant_valid) begin
			cur_ch <= grant_ch;
			cur_wr <= grant_wr;
		end
		if (state == mpmc_pkg::PRESET) begin
			cur_line <= line_adr_all[cur_ch];
			mem_wdf_data <= wr_line_all[cur_ch];
			mem_wdf_mask <= wr_mask_all[cur_ch];
		end
		if (state == mpmc_pkg::WAIT_RD && mem_rd_data_valid)
			fill_data <= mem_rd_data;
	end

endmodule

//--- src/mpmc_top.sv
`timescale 1ns/100ps
`include "mpmc_consts.svh"

module mpmc_top (
	input  logic                           mem_ui_clk,
	input  logic                           mem_ui_rst,
	// Display channel, read only
	input  logic                           cyc0,
	input  mpmc_pkg::addr_t                adr0,
	output logic                           ack0,
	output logic [127:0]                   dato0,
	// Processor channel
	input  logic                           cyc1,
	input  logic                           we1,
	input  logic [15:0]                    sel1,
	input  mpmc_pkg::addr_t                adr1,
	input  logic [127:0]                   dati1,
	output logic                           ack1,
	output logic [127:0]                   dato1,
	// Peripheral channel
	input  logic                           cyc2,
	input  logic                           we2,
	input  logic [3:0]                     sel2,
	input  mpmc_pkg::addr_t                adr2,
	input  logic [31:0]                    dati2,
	output logic                           ack2,
	output logic [31:0]                    dato2,
	// Memory user interface
	output logic                           mem_en,
	output mpmc_pkg::mem_cmd_t             mem_cmd,
	output logic [`MPMC_MEM_ADDR_BITS-1:0] mem_addr,
	output logic                           mem_wdf_wren,
	output logic                           mem_wdf_end,
	output mpmc_pkg::line_t                mem_wdf_data,
	output mpmc_pkg::mask_t                mem_wdf_mask,
	input  logic                           mem_rdy,
	input  logic                           mem_wdf_rdy,
	input  mpmc_pkg::line_t                mem_rd_data,
	input  logic                           mem_rd_data_valid
);
	logic [`MPMC_NUM_CH-1:0]            svc_req;
	logic [`MPMC_NUM_CH-1:0]            svc_wr;
	logic [`MPMC_NUM_CH-1:0]            fill_hit;
	logic [`MPMC_NUM_CH-1:0]            wr_done;
	mpmc_pkg::addr_t [`MPMC_NUM_CH-1:0] line_adr;
	mpmc_pkg::line_t [`MPMC_NUM_CH-1:0] wr_line;
	mpmc_pkg::mask_t [`MPMC_NUM_CH-1:0] wr_mask;
	logic                               grant_valid;
	mpmc_pkg::ch_idx_t                  grant_ch;
	logic                               grant_wr;
	logic                               busy;
	logic                               fill_valid;
	mpmc_pkg::ch_idx_t                  fill_ch;
	mpmc_pkg::line_t                    fill_data;
	logic                               wr_done_valid;
	mpmc_pkg::ch_idx_t                  wr_done_ch;
	logic                               inval_valid;
	mpmc_pkg::addr_t                    inval_line;

	// Turn the sequencer's channel index into per-channel strobes
	always_comb begin
		for (int i = 0; i < `MPMC_NUM_CH; i++) begin
			fill_hit[i] = fill_valid && (fill_ch == mpmc_pkg::ch_idx_t'(i));
			wr_done[i] = wr_done_valid && (wr_done_ch == mpmc_pkg::ch_idx_t'(i));
		end
	end

	assign grant_wr = svc_wr[grant_ch];

	// ============================
	// Channels
	// ============================
	mpmc_channel #(.DATA_BITS(128)) u_ch0 (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cyc(cyc0), .we(1'b0), .sel('1), .adr(adr0), .dati('0),
		.ack(ack0), .dato(dato0),
		.svc_req(svc_req[0]), .svc_wr(svc_wr[0]),
		.line_adr(line_adr[0]), .wr_line(wr_line[0]), .wr_mask(wr_mask[0]),
		.fill_hit(fill_hit[0]), .fill_data(fill_data), .wr_done(wr_done[0]),
		.inval_valid(inval_valid), .inval_line(inval_line)
	);

	mpmc_channel #(.DATA_BITS(128)) u_ch1 (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cyc(cyc1), .we(we1), .sel(sel1), .adr(adr1), .dati(dati1),
		.ack(ack1), .dato(dato1),
		.svc_req(svc_req[1]), .svc_wr(svc_wr[1]),
		.line_adr(line_adr[1]), .wr_line(wr_line[1]), .wr_mask(wr_mask[1]),
		.fill_hit(fill_hit[1]), .fill_data(fill_data), .wr_done(wr_done[1]),
		.inval_valid(inval_valid), .inval_line(inval_line)
	);

	mpmc_channel #(.DATA_BITS(32)) u_ch2 (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cyc(cyc2), .we(we2), .sel(sel2), .adr(adr2), .dati(dati2),
		.ack(ack2), .dato(dato2),
		.svc_req(svc_req[2]), .svc_wr(svc_wr[2]),
		.line_adr(line_adr[2]), .wr_line(wr_line[2]), .wr_mask(wr_mask[2]),
		.fill_hit(fill_hit[2]), .fill_data(fill_data), .wr_done(wr_done[2]),
		.inval_valid(inval_valid), .inval_line(inval_line)
	);

	// ============================
	// Arbiter and sequencer
	// ============================
	mpmc_arbiter u_arb (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.svc_req(svc_req), .svc_wr(svc_wr), .busy(busy),
		.grant_valid(grant_valid), .grant_ch(grant_ch)
	);

	mpmc_sequencer u_seq (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.grant_valid(grant_valid), .grant_ch(grant_ch), .grant_wr(grant_wr),
		.line_adr_all(line_adr), .wr_line_all(wr_line), .wr_mask_all(wr_mask),
		.busy(busy),
		.fill_valid(fill_valid), .fill_ch(fill_ch), .fill_data(fill_data),
		.wr_done_valid(wr_done_valid), .wr_done_ch(wr_done_ch),
		.inval_valid(inval_valid), .inval_line(inval_line),
		.mem_en(mem_en), .mem_cmd(mem_cmd), .mem_addr(mem_addr),
		.mem_wdf_wren(mem_wdf_wren), .mem_wdf_end(mem_wdf_end),
		.mem_wdf_data(mem_wdf_data), .mem_wdf_mask(mem_wdf_mask),
		.mem_rdy(mem_rdy), .mem_wdf_rdy(mem_wdf_rdy),
		.mem_rd_data(mem_rd_data), .mem_rd_data_valid(mem_rd_data_valid)
	);

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic mem_ui_clk,
	output logic mem_ui_rst
);
	// 40 ns period
	initial begin
		mem_ui_clk = 1'b0;
		forever #20 mem_ui_clk = ~mem_ui_clk;
	end

	// Two rising edges in reset, released on a falling edge
	initial begin
		mem_ui_rst = 1'b1;
		repeat (2) @(posedge mem_ui_clk);
		@(negedge mem_ui_clk);
		mem_ui_rst = 1'b0;
	end

endmodule

//--- testbench/mem_model.sv
`timescale 1ns/100ps
`include "mpmc_consts.svh"

module mem_model (
	input  logic                           mem_ui_clk,
	input  logic                           mem_ui_rst,
	input  logic [31:0]                    rnd,
	input  logic                           load_en,
	input  logic [5:0]                     load_idx,
	input  mpmc_pkg::line_t                load_data,
	input  logic                           mem_en,
	input  mpmc_pkg::mem_cmd_t             mem_cmd,
	input  logic [`MPMC_MEM_ADDR_BITS-1:0] mem_addr,
	input  logic                           mem_wdf_wren,
	input  logic                           mem_wdf_end,
	input  mpmc_pkg::line_t                mem_wdf_data,
	input  mpmc_pkg::mask_t                mem_wdf_mask,
	output logic                           mem_rdy,
	output logic                           mem_wdf_rdy,
	output mpmc_pkg::line_t                mem_rd_data,
	output logic                           mem_rd_data_valid
);
	mpmc_pkg::line_t store [64];
	mpmc_pkg::line_t wdf_line;
	mpmc_pkg::mask_t wdf_mask;
	logic [5:0]      cmd_idx;
	logic [5:0]      rd_idx;
	logic [2:0]      rd_wait;
	logic            rd_pending;

	// Ready three cycles out of four, set by the random word
	assign mem_rdy = rnd[0] | rnd[1];
	assign mem_wdf_rdy = rnd[2] | rnd[3];
	assign cmd_idx = mem_addr[9:4];

	// Write data arrives ahead of its command
	always_ff @(posedge mem_ui_clk) begin
		if (mem_wdf_wren && mem_wdf_end && mem_wdf_rdy) begin
			wdf_line <= mem_wdf_data;
			wdf_mask <= mem_wdf_mask;
		end
	end

	// Preload port, then masked writes (a set mask bit keeps the byte)
	always_ff @(posedge mem_ui_clk) begin
		if (load_en) begin
			store[load_idx] <= load_data;
		end else if (mem_en && mem_rdy && mem_cmd == mpmc_pkg::CMD_WRITE) begin
			for (int b = 0; b < `MPMC_MASK_BITS; b++) begin
				if (!wdf_mask[b])
					store[cmd_idx][b * 8 +: 8] <= wdf_line[b * 8 +: 8];
			end
		end
	end

	// ============================
	// Reads with 1 to 8 cycles of latency
	// ============================
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			rd_pending <= 1'b0;
			rd_wait <= 3'd0;
			mem_rd_data_valid <= 1'b0;
		end else begin
			mem_rd_data_valid <= 1'b0;
			if (mem_en && mem_rdy && mem_cmd == mpmc_pkg::CMD_READ) begin
				rd_pending <= 1'b1;
				rd_idx <= cmd_idx;
				rd_wait <= rnd[6:4];
			end else if (rd_pending) begin
				if (rd_wait == 3'd0) begin
					rd_pending <= 1'b0;
					mem_rd_data_valid <= 1'b1;
					mem_rd_data <= store[rd_idx];
				end else begin
					rd_wait <= rd_wait - 3'd1;
				end
			end
		end
	end

endmodule

//--- testbench/tb_mpmc.sv
`timescale 1ns/100ps
`include "mpmc_consts.svh"

module tb_mpmc;
	localparam logic [31:0] SEED = 32'h93ee;
	localparam int CYCLES_PER_ENTRY = 200;
	localparam int MEM_LINES = 64;

	typedef struct packed {
		logic [1:0]      ch;
		logic            we;
		mpmc_pkg::addr_t adr;
		logic [15:0]     sel;
		mpmc_pkg::line_t data;
		logic            mem_access;
	} entry_t;

	logic mem_ui_clk, mem_ui_rst;
	logic cyc0, ack0, cyc1, we1, ack1, cyc2, we2, ack2;
	mpmc_pkg::addr_t adr0, adr1, adr2;
	logic [127:0] dato0, dati1, dato1;
	logic [15:0] sel1;
	logic [3:0] sel2;
	logic [31:0] dati2, dato2;
	logic mem_en, mem_wdf_wren, mem_wdf_end, mem_rdy, mem_wdf_rdy, mem_rd_data_valid;
	mpmc_pkg::mem_cmd_t mem_cmd;
	logic [`MPMC_MEM_ADDR_BITS-1:0] mem_addr;
	mpmc_pkg::line_t mem_wdf_data, mem_rd_data, load_data;
	mpmc_pkg::mask_t mem_wdf_mask;
	logic [31:0] rnd;
	logic load_en;
	logic [5:0] load_idx;

	mpmc_pkg::line_t shadow [MEM_LINES];
	entry_t entries[$];
	mpmc_pkg::mem_cmd_t accepted_cmds[$];
	logic [31:0] rng_state = SEED;
	int en_cycles = 0;
	logic table_ready = 1'b0;

	tb_clock u_clock (.*);
	mem_model u_mem (.*);
	mpmc_top dut (.*);

	// ============================
	// Random numbers and table
	// ============================
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Each word is mixed with the line's byte address
	function automatic mpmc_pkg::line_t init_line(input int idx);
		logic [31:0] a;
		a = 32'(idx) << 4;
		return {next_rand() ^ a, next_rand() ^ a, next_rand() ^ a, next_rand() ^ a};
	endfunction

	function automatic void add_entry(input logic [1:0] ch, input logic we,
		input mpmc_pkg::addr_t adr, input logic [15:0] sel,
		input mpmc_pkg::line_t data, input logic mem_access);
		entries.push_back({ch, we, adr, sel, data, mem_access});
	endfunction

	task automatic build_table();
		// Processor channel: miss, hit, masked write, refill, hit
		add_entry(2'd1, 1'b0, 32'h100, 16'hffff, '0, 1'b1);
		add_entry(2'd1, 1'b0, 32'h100, 16'hffff, '0, 1'b0);
		add_entry(2'd1, 1'b1, 32'h100, 16'h0f3c,
			{next_rand(), next_rand(), next_rand(), next_rand()}, 1'b1);
		add_entry(2'd1, 1'b0, 32'h100, 16'hffff, '0, 1'b1);
		add_entry(2'd1, 1'b0, 32'h104, 16'hffff, '0, 1'b0);
		// Peripheral channel, one word per lane, then read back
		for (int i = 0; i < 4; i++)
			add_entry(2'd2, 1'b1, 32'h200 + 32'(4 * i), 16'h000f >> i,
				{96'b0, next_rand()}, 1'b1);
		for (int i = 0; i < 4; i++)
			add_entry(2'd2, 1'b0, 32'h200 + 32'(4 * i), 16'h000f, '0, i == 0);
		// Display channel sees a peripheral write
		add_entry(2'd0, 1'b0, 32'h300, 16'hffff, '0, 1'b1);
		add_entry(2'd0, 1'b0, 32'h300, 16'hffff, '0, 1'b0);
		add_entry(2'd2, 1'b1, 32'h308, 16'h000f, {96'b0, next_rand()}, 1'b1);
		add_entry(2'd0, 1'b0, 32'h300, 16'hffff, '0, 1'b1);
		add_entry(2'd1, 1'b0, 32'h200, 16'hffff, '0, 1'b1);
	endtask

	// ============================
	// Checks
	// ============================
	task automatic fail_run(input string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_line(input mpmc_pkg::line_t got, input mpmc_pkg::line_t exp,
		input string what);
		if (got !== exp)
			fail_run($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			fail_run($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic check_cmd(input mpmc_pkg::mem_cmd_t got, input mpmc_pkg::mem_cmd_t exp,
		input string what);
		if (got !== exp)
			fail_run($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("%s: got %b, expected %b", what, got, exp));
	endtask

	// Selected bytes replace the shadow line, the rest stay
	task automatic shadow_write(input entry_t e);
		int nbytes;
		int base;
		nbytes = (e.ch == 2'd2) ? 4 : 16;
		base = (e.ch == 2'd2) ? 4 * int'(e.adr[3:2]) : 0;
		for (int j = 0; j < nbytes; j++) begin
			if (e.sel[j])
				shadow[e.adr[9:4]][(base + j) * 8 +: 8] = e.data[j * 8 +: 8];
		end
	endtask

	function automatic mpmc_pkg::line_t read_value(input entry_t e);
		mpmc_pkg::line_t l;
		l = shadow[e.adr[9:4]];
		if (e.ch == 2'd2)
			return {96'b0, l[int'(e.adr[3:2]) * 32 +: 32]};
		return l;
	endfunction

	function automatic logic ack_of(input logic [1:0] ch);
		case (ch)
			2'd0: return ack0;
			2'd1: return ack1;
			default: return ack2;
		endcase
	endfunction

	// ============================
	// Requester driving
	// ============================
	task automatic drive_request(input entry_t e);
		case (e.ch)
			2'd0: begin
				cyc0 = 1'b1;
				adr0 = e.adr;
			end
			2'd1: begin
				cyc1 = 1'b1;
				we1 = e.we;
				sel1 = e.sel;
				adr1 = e.adr;
				dati1 = e.data;
			end
			default: begin
				cyc2 = 1'b1;
				we2 = e.we;
				sel2 = e.sel[3:0];
				adr2 = e.adr;
				dati2 = e.data[31:0];
			end
		endcase
	endtask

	task automatic run_entry(input entry_t e, input int n);
		int en_before;
		mpmc_pkg::line_t exp;
		@(negedge mem_ui_clk);
		en_before = en_cycles;
		drive_request(e);
		do begin
			@(negedge mem_ui_clk);
		end while (!ack_of(e.ch));
		if (e.we) begin
			shadow_write(e);
		end else begin
			exp = read_value(e);
			if (e.ch == 2'd2)
				check_word(dato2, exp[31:0], $sformatf("entry %0d dato2", n));
			else if (e.ch == 2'd1)
				check_line(dato1, exp, $sformatf("entry %0d dato1", n));
			else
				check_line(dato0, exp, $sformatf("entry %0d dato0", n));
		end
		check_flag(en_cycles != en_before, e.mem_access, $sformatf("entry %0d mem_en", n));
		cyc0 = 1'b0;
		cyc1 = 1'b0;
		cyc2 = 1'b0;
		@(negedge mem_ui_clk);
		check_flag(ack_of(e.ch), 1'b0, $sformatf("entry %0d ack width", n));
	endtask

	// Read miss and write raised together, the write goes first
	task automatic run_write_read_race();
		entry_t rd;
		entry_t wr;
		logic got0;
		logic got2;
		rd = {2'd0, 1'b0, 32'h380, 16'hffff, 128'b0, 1'b1};
		wr = {2'd2, 1'b1, 32'h384, 16'h000f, {96'b0, next_rand()}, 1'b1};
		got0 = 1'b0;
		got2 = 1'b0;
		@(negedge mem_ui_clk);
		accepted_cmds.delete();
		drive_request(rd);
		drive_request(wr);
		while (!(got0 && got2)) begin
			@(negedge mem_ui_clk);
			if (ack2 && !got2) begin
				got2 = 1'b1;
				shadow_write(wr);
				cyc2 = 1'b0;
			end
			if (ack0 && !got0) begin
				got0 = 1'b1;
				check_line(dato0, read_value(rd), "race read dato0");
				cyc0 = 1'b0;
			end
		end
		if (accepted_cmds.size() == 0)
			fail_run("no memory command was accepted");
		else
			check_cmd(accepted_cmds[0], mpmc_pkg::CMD_WRITE, "first accepted mem_cmd");
	endtask

	// Memory port activity seen on rising edges
	always @(posedge mem_ui_clk) begin
		if (mem_en)
			en_cycles <= en_cycles + 1;
		if (mem_en && mem_rdy)
			accepted_cmds.push_back(mem_cmd);
	end

	// Stall and latency word for the memory model
	always @(negedge mem_ui_clk) begin
		rnd <= next_rand();
	end

	initial begin
		int limit;
		wait (table_ready);
		limit = (entries.size() + 2) * CYCLES_PER_ENTRY + MEM_LINES;
		repeat (limit) @(posedge mem_ui_clk);
		$display("Timeout: the DUT stopped acknowledging requests");
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		{cyc0, cyc1, we1, cyc2, we2} = '0;
		{adr0, adr1, adr2} = '0;
		sel1 = '0;
		sel2 = '0;
		dati1 = '0;
		dati2 = '0;
		rnd = '1;
		load_en = 1'b0;
		load_idx = '0;
		load_data = '0;
		for (int i = 0; i < MEM_LINES; i++)
			shadow[i] = init_line(i);
		build_table();
		table_ready = 1'b1;
		wait (!mem_ui_rst);
		// Preload memory while the DUT must stay quiet
		for (int i = 0; i < MEM_LINES; i++) begin
			@(negedge mem_ui_clk);
			check_flag(ack0 | ack1 | ack2, 1'b0, "ack before any request");
			check_flag(mem_en, 1'b0, "mem_en before any request");
			check_flag(mem_wdf_wren, 1'b0, "mem_wdf_wren before any request");
			load_en = 1'b1;
			load_idx = 6'(i);
			load_data = shadow[i];
		end
		@(negedge mem_ui_clk);
		load_en = 1'b0;
		foreach (entries[i])
			run_entry(entries[i], i);
		run_write_read_race();
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- tb.f
+incdir+src
src/mpmc_pkg.sv
src/mpmc_channel.sv
src/mpmc_arbiter.sv
src/mpmc_sequencer.sv
src/mpmc_top.sv
testbench/tb_clock.sv
testbench/mem_model.sv
testbench/tb_mpmc.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_mpmc
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vtb_mpmc
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0
